/* aluExecute.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module aluExecute (
    input  mipsPkg::aluOp_e    aluOp_i,
    input  mipsPkg::word_t     opA_i,
    input  mipsPkg::word_t     opB_i,
    input  mipsPkg::word_t     regbRaw_i,
    input  logic               regcWr_i,
    input  mipsPkg::regAddr_t  regcAddr_i,
    input  mipsPkg::word_t     brTarget_i,
    output mipsPkg::word_t     aluResult_o,
    output logic               wrEn_o,
    output mipsPkg::regAddr_t  wrAddr_o,
    output logic               jTaken_o,
    output mipsPkg::word_t     jTarget_o
);
    import mipsPkg::*;

    localparam int ShW = $clog2(`MIPS_DATA_W);

    logic [ShW-1:0] shAmt;
    logic           aZero;
    logic           aNeg;

    assign shAmt = opB_i[ShW-1:0];
    assign aZero = (opA_i == '0);
    assign aNeg  = opA_i[`MIPS_DATA_W-1];

    ////////////////////
    // alu
    ////////////////////

    always_comb
    begin
        case (aluOp_i)
            AluAnd:          aluResult_o = opA_i & opB_i;
            AluOr:           aluResult_o = opA_i | opB_i;
            AluXor:          aluResult_o = opA_i ^ opB_i;
            AluAdd:          aluResult_o = opA_i + opB_i;    // wraps
            AluSub:          aluResult_o = opA_i - opB_i;
            AluSlt:          aluResult_o = word_t'($signed(opA_i) < $signed(opB_i));
            AluSll:          aluResult_o = opA_i << shAmt;
            AluSrl:          aluResult_o = opA_i >> shAmt;
            AluSra:          aluResult_o = word_t'($signed(opA_i) >>> shAmt);
            AluLui:          aluResult_o = opB_i;
            AluJal, AluJalr: aluResult_o = opA_i;            // link value
            default:         aluResult_o = '0;
        endcase
    end

    ////////////////////
    // branch decision
    ////////////////////

    always_comb
    begin
        case (aluOp_i)
            AluBeq:                     jTaken_o = (opA_i == regbRaw_i);
            AluBne:                     jTaken_o = (opA_i != regbRaw_i);
            AluBgtz:                    jTaken_o = !aNeg && !aZero;
            AluBltz:                    jTaken_o = aNeg;
            AluJ, AluJal, AluJr, AluJalr: jTaken_o = 1'b1;
            default:                    jTaken_o = 1'b0;
        endcase
    end

    assign wrEn_o    = regcWr_i;
    assign wrAddr_o  = regcAddr_i;
    assign jTarget_o = brTarget_i;

endmodule

/* files.f */
+incdir+.
mipsPkg.sv
instDecode.sv
aluExecute.sv
regFile.sv
resultStage.sv
mipsCore.sv
tb_mipsCore.sv

/* instDecode.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module instDecode (
    input  logic               instValid_i,
    input  mipsPkg::word_t     inst_i,
    input  mipsPkg::word_t     pc_i,
    input  mipsPkg::word_t     regaData_i,
    input  mipsPkg::word_t     regbData_i,
    output mipsPkg::regAddr_t  regaAddr_o,
    output mipsPkg::regAddr_t  regbAddr_o,
    output mipsPkg::aluOp_e    aluOp_o,
    output mipsPkg::word_t     opA_o,
    output mipsPkg::word_t     opB_o,
    output logic               regcWr_o,
    output mipsPkg::regAddr_t  regcAddr_o,
    output mipsPkg::word_t     brTarget_o
);
    import mipsPkg::*;

    opcode_e  opcode;
    funct_e   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    word_t    pcPlus4;
    word_t    immSext;
    word_t    immZext;
    word_t    immLui;
    word_t    immShamt;
    word_t    brOffset;
    word_t    branchTgt;
    word_t    jumpTgt;
    word_t    imm;
    logic     useImm;
    logic     linkPc;
    aluOp_e   aluOp;
    logic     regcWr;

    ////////////////////
    // field split
    ////////////////////

    assign opcode   = opcode_e'(inst_i[31:26]);
    assign funct    = funct_e'(inst_i[5:0]);
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign pcPlus4  = pc_i + word_t'(4);

    assign immSext  = {{(`MIPS_DATA_W-16){inst_i[15]}}, inst_i[15:0]};
    assign immZext  = {{(`MIPS_DATA_W-16){1'b0}}, inst_i[15:0]};
    assign immLui   = {inst_i[15:0], {(`MIPS_DATA_W-16){1'b0}}};
    assign immShamt = {{(`MIPS_DATA_W-5){1'b0}}, inst_i[10:6]};
    assign brOffset = {immSext[`MIPS_DATA_W-3:0], 2'b00};   // word offset in bytes

    assign branchTgt = pcPlus4 + brOffset;
    assign jumpTgt   = {pcPlus4[`MIPS_DATA_W-1:`MIPS_DATA_W-4], inst_i[25:0], 2'b00};

    ////////////////////
    // opcode decode
    ////////////////////

    always_comb
    begin
        aluOp      = AluNop;
        regcWr     = 1'b0;
        regaAddr_o = '0;
        regbAddr_o = '0;
        regcAddr_o = '0;
        imm        = '0;
        useImm     = 1'b0;
        linkPc     = 1'b0;
        case (opcode)
            OpSpecial:
            begin
                regaAddr_o = rs;
                regbAddr_o = rt;
                regcAddr_o = rd;
                case (funct)
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnAdd:   aluOp = AluAdd;
                    FnSub:   aluOp = AluSub;
                    FnSlt:   aluOp = AluSlt;
                    FnSll:   aluOp = AluSll;
                    FnSrl:   aluOp = AluSrl;
                    FnSra:   aluOp = AluSra;
                    FnJr:    aluOp = AluJr;
                    FnJalr:  aluOp = AluJalr;
                    default: aluOp = AluNop;
                endcase
                if (aluOp inside {AluSll, AluSrl, AluSra})
                begin
                    regaAddr_o = rt;        // shifts operate on rt
                    regbAddr_o = '0;
                    imm        = immShamt;
                    useImm     = 1'b1;
                end
                if (aluOp inside {AluJr, AluJalr})
                    regbAddr_o = '0;
                regcWr = (aluOp != AluNop) && (aluOp != AluJr);
                linkPc = (aluOp == AluJalr);
            end
            OpAddi, OpAndi, OpOri, OpXori:
            begin
                case (opcode)
                    OpAddi:  aluOp = AluAdd;
                    OpAndi:  aluOp = AluAnd;
                    OpOri:   aluOp = AluOr;
                    default: aluOp = AluXor;
                endcase
                regaAddr_o = rs;
                regcAddr_o = rt;
                regcWr     = 1'b1;
                imm        = (opcode == OpAddi) ? immSext : immZext;
                useImm     = 1'b1;
            end
            OpLui:
            begin
                aluOp      = AluLui;
                regcAddr_o = rt;
                regcWr     = 1'b1;
                imm        = immLui;
                useImm     = 1'b1;
            end
            OpBeq, OpBne:
            begin
                aluOp      = (opcode == OpBeq) ? AluBeq : AluBne;
                regaAddr_o = rs;
                regbAddr_o = rt;
                imm        = brOffset;
                useImm     = 1'b1;
            end
            OpBgtz, OpBltz:
            begin
                aluOp      = (opcode == OpBgtz) ? AluBgtz : AluBltz;
                regaAddr_o = rs;
                imm        = brOffset;
                useImm     = 1'b1;
            end
            OpJ:
                aluOp = AluJ;
            OpJal:
            begin
                aluOp      = AluJal;
                regcAddr_o = regAddr_t'(`MIPS_LINK_REG);
                regcWr     = 1'b1;
                linkPc     = 1'b1;
            end
            default:
                aluOp = AluNop;
        endcase
        if (!instValid_i)
        begin
            aluOp  = AluNop;            // bubble
            regcWr = 1'b0;
        end
    end

    assign aluOp_o    = aluOp;
    assign regcWr_o   = regcWr;
    assign opA_o      = linkPc ? pcPlus4 : regaData_i;   // return address
    assign opB_o      = useImm ? imm : regbData_i;
    assign brTarget_o = (aluOp inside {AluJr, AluJalr}) ? regaData_i :
                        (aluOp inside {AluJ, AluJal})   ? jumpTgt    : branchTgt;

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               instValid_i,
    input  mipsPkg::word_t     inst_i,
    input  mipsPkg::word_t     pc_i,
    output logic               wrEn_o,
    output mipsPkg::regAddr_t  wrAddr_o,
    output mipsPkg::word_t     wrData_o,
    output logic               jCe_o,
    output mipsPkg::word_t     jAddr_o
);
    import mipsPkg::*;

    regAddr_t regaAddr;
    regAddr_t regbAddr;
    word_t    regaData;
    word_t    regbData;
    aluOp_e   aluOp;
    word_t    opA;
    word_t    opB;
    logic     regcWr;
    regAddr_t regcAddr;
    word_t    brTarget;
    word_t    aluResult;
    logic     wrEn;
    regAddr_t wrAddr;
    logic     jTaken;
    word_t    jTarget;

    instDecode i_instDecode (
        .instValid_i (instValid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .regaData_i  (regaData),
        .regbData_i  (regbData),
        .regaAddr_o  (regaAddr),
        .regbAddr_o  (regbAddr),
        .aluOp_o     (aluOp),
        .opA_o       (opA),
        .opB_o       (opB),
        .regcWr_o    (regcWr),
        .regcAddr_o  (regcAddr),
        .brTarget_o  (brTarget)
    );

    aluExecute i_aluExecute (
        .aluOp_i     (aluOp),
        .opA_i       (opA),
        .opB_i       (opB),
        .regbRaw_i   (regbData),     // compare operand for beq/bne
        .regcWr_i    (regcWr),
        .regcAddr_i  (regcAddr),
        .brTarget_i  (brTarget),
        .aluResult_o (aluResult),
        .wrEn_o      (wrEn),
        .wrAddr_o    (wrAddr),
        .jTaken_o    (jTaken),
        .jTarget_o   (jTarget)
    );

    resultStage i_resultStage (
        .clk         (clk),
        .rst_i       (rst_i),
        .raAddr_i    (regaAddr),
        .rbAddr_i    (regbAddr),
        .aluResult_i (aluResult),
        .wrEn_i      (wrEn),
        .wrAddr_i    (wrAddr),
        .jTaken_i    (jTaken),
        .jTarget_i   (jTarget),
        .raData_o    (regaData),
        .rbData_o    (regbData),
        .wrEn_o      (wrEn_o),
        .wrAddr_o    (wrAddr_o),
        .wrData_o    (wrData_o),
        .jCe_o       (jCe_o),
        .jAddr_o     (jAddr_o)
    );

endmodule

/* mipsPkg.sv */
`include "mips_cfg.svh"

package mipsPkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] regAddr_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OpSpecial = 6'b000000,
        OpBltz    = 6'b000001,
        OpJ       = 6'b000010,
        OpJal     = 6'b000011,
        OpBeq     = 6'b000100,
        OpBne     = 6'b000101,
        OpBgtz    = 6'b000111,
        OpAddi    = 6'b001000,
        OpAndi    = 6'b001100,
        OpOri     = 6'b001101,
        OpXori    = 6'b001110,
        OpLui     = 6'b001111
    } opcode_e;

    // special group, inst[5:0]
    typedef enum logic [5:0] {
        FnSll  = 6'b000000,
        FnSrl  = 6'b000010,
        FnSra  = 6'b000011,
        FnJr   = 6'b001000,
        FnJalr = 6'b001001,
        FnAdd  = 6'b100000,
        FnSub  = 6'b100010,
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnXor  = 6'b100110,
        FnSlt  = 6'b101010
    } funct_e;

    typedef enum logic [4:0] {
        AluNop, AluAnd, AluOr, AluXor, AluAdd, AluSub, AluSlt,
        AluSll, AluSrl, AluSra, AluLui,
        AluBeq, AluBne, AluBgtz, AluBltz,
        AluJ, AluJal, AluJr, AluJalr
    } aluOp_e;

endpackage

/* mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

////////////////////
// datapath sizing
////////////////////

`define MIPS_DATA_W   32    // word width
`define MIPS_REG_AW   5     // register address bits
`define MIPS_NUM_REGS 32    // general purpose registers

////////////////////
// fixed registers
////////////////////

`define MIPS_LINK_REG 31    // jal return address

`endif

/* regFile.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regFile (
    input  logic               clk,
    input  logic               rst_i,
    input  mipsPkg::regAddr_t  raAddr_i,
    input  mipsPkg::regAddr_t  rbAddr_i,
    input  logic               wrEn_i,
    input  mipsPkg::regAddr_t  wrAddr_i,
    input  mipsPkg::word_t     wrData_i,
    output mipsPkg::word_t     raData_o,
    output mipsPkg::word_t     rbData_o
);
    import mipsPkg::*;

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wrEn_i && (wrAddr_i != '0))
            regs[wrAddr_i] <= wrData_i;
    end

    // r0 reads zero, pending write bypasses the array
    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0)
            return '0;
        else if (wrEn_i && (wrAddr_i == addr))
            return wrData_i;
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        raData_o = readPort(raAddr_i);
        rbData_o = readPort(rbAddr_i);
    end

endmodule

/* resultStage.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module resultStage (
    input  logic               clk,
    input  logic               rst_i,
    input  mipsPkg::regAddr_t  raAddr_i,
    input  mipsPkg::regAddr_t  rbAddr_i,
    input  mipsPkg::word_t     aluResult_i,
    input  logic               wrEn_i,
    input  mipsPkg::regAddr_t  wrAddr_i,
    input  logic               jTaken_i,
    input  mipsPkg::word_t     jTarget_i,
    output mipsPkg::word_t     raData_o,
    output mipsPkg::word_t     rbData_o,
    output logic               wrEn_o,
    output mipsPkg::regAddr_t  wrAddr_o,
    output mipsPkg::word_t     wrData_o,
    output logic               jCe_o,
    output mipsPkg::word_t     jAddr_o
);
    import mipsPkg::*;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wrEn_o   <= 1'b0;
            wrAddr_o <= '0;
            wrData_o <= '0;
            jCe_o    <= 1'b0;
            jAddr_o  <= '0;
        end
        else
        begin
            wrEn_o   <= wrEn_i && (wrAddr_i != '0);  // r0 writes dropped
            wrAddr_o <= wrAddr_i;
            wrData_o <= aluResult_i;
            jCe_o    <= jTaken_i;
            jAddr_o  <= jTarget_i;
        end
    end

    regFile i_regFile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raAddr_i (raAddr_i),
        .rbAddr_i (rbAddr_i),
        .wrEn_i   (wrEn_o),        // registered writeback
        .wrAddr_i (wrAddr_o),
        .wrData_i (wrData_o),
        .raData_o (raData_o),
        .rbData_o (rbData_o)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_mipsCore -o simv
out=$(./obj_dir/simv)
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

/* tb_mipsCore.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mipsCore;
    import mipsPkg::*;

    localparam int ClkPeriod = 40;
    localparam int NumAlu    = 200;
    localparam int NumImm    = 120;
    localparam int NumBr     = 80;
    localparam int NumJmp    = 40;
    // bubbles can double the alu section
    localparam int MaxCycles = 5 + 62 + 2 * NumAlu + NumImm + NumBr + 2 * NumJmp + 100;

    typedef struct packed {
        logic                    full;      // reset entry, every field compared
        logic                    wrEn;
        logic [`MIPS_REG_AW-1:0] wrAddr;
        word_t                   wrData;
        logic                    jCe;
        word_t                   jAddr;
    } expect_t;

    logic     clk;
    logic     rst_i;
    logic     instValid_i;
    word_t    inst_i;
    word_t    pc_i;
    logic     wrEn_o;
    regAddr_t wrAddr_o;
    word_t    wrData_o;
    logic     jCe_o;
    word_t    jAddr_o;

    word_t       shadow [`MIPS_NUM_REGS];
    expect_t     expQ [$];
    expect_t     cur;
    logic        chkWr;
    logic        chkJ;
    logic [15:0] lfsr = 16'd21440;
    int          errors = 0;
    int          checks = 0;

    mipsCore i_mipsCore (
        .clk         (clk),
        .rst_i       (rst_i),
        .instValid_i (instValid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .wrEn_o      (wrEn_o),
        .wrAddr_o    (wrAddr_o),
        .wrData_o    (wrData_o),
        .jCe_o       (jCe_o),
        .jAddr_o     (jAddr_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic word_t randBits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t randPc();
        return randBits(30) << 2;           // word aligned
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(randBits(5));
    endfunction

    function automatic word_t rType(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] sh,
                                    input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [5:0] randAluFunct();
        case (randBits(4) % 9)
            0:       return FnAnd;
            1:       return FnOr;
            2:       return FnXor;
            3:       return FnAdd;
            4:       return FnSub;
            5:       return FnSlt;
            6:       return FnSll;
            7:       return FnSrl;
            default: return FnSra;
        endcase
    endfunction

    function automatic logic [5:0] randImmOp();
        case (randBits(3) % 5)
            0:       return OpAddi;
            1:       return OpAndi;
            2:       return OpOri;
            3:       return OpXori;
            default: return OpLui;
        endcase
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    function automatic expect_t predict(input logic valid, input word_t inst, input word_t pc);
        expect_t    e;
        word_t      a;
        word_t      b;
        word_t      pc4;
        word_t      sImm;
        word_t      zImm;
        word_t      res;
        logic [4:0] dst;
        logic       wr;
        e = '0;
        if (!valid)
            return e;
        a    = shadow[inst[25:21]];
        b    = shadow[inst[20:16]];
        pc4  = pc + 32'd4;
        sImm = {{16{inst[15]}}, inst[15:0]};
        zImm = {16'h0000, inst[15:0]};
        res  = '0;
        dst  = inst[20:16];                 // rt unless overridden
        wr   = 1'b1;
        case (inst[31:26])
            OpSpecial:
            begin
                dst = inst[15:11];
                case (inst[5:0])
                    FnAnd: res = a & b;
                    FnOr:  res = a | b;
                    FnXor: res = a ^ b;
                    FnAdd: res = a + b;
                    FnSub: res = a - b;
                    FnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FnSll: res = b << inst[10:6];
                    FnSrl: res = b >> inst[10:6];
                    FnSra: res = $signed(b) >>> inst[10:6];
                    FnJr:
                    begin
                        wr      = 1'b0;
                        e.jCe   = 1'b1;
                        e.jAddr = a;
                    end
                    FnJalr:
                    begin
                        res     = pc4;
                        e.jCe   = 1'b1;
                        e.jAddr = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OpAddi: res = a + sImm;
            OpAndi: res = a & zImm;
            OpOri:  res = a | zImm;
            OpXori: res = a ^ zImm;
            OpLui:  res = {inst[15:0], 16'h0000};
            OpJ, OpJal:
            begin
                wr      = (inst[31:26] == OpJal);
                dst     = 5'(`MIPS_LINK_REG);
                res     = pc4;
                e.jCe   = 1'b1;
                e.jAddr = {pc4[31:28], inst[25:0], 2'b00};
            end
            default:
            begin
                wr      = 1'b0;
                e.jAddr = pc4 + (sImm << 2);
                case (inst[31:26])
                    OpBeq:   e.jCe = (a == b);
                    OpBne:   e.jCe = (a != b);
                    OpBgtz:  e.jCe = ($signed(a) > 0);
                    OpBltz:  e.jCe = ($signed(a) < 0);
                    default: e.jCe = 1'b0;
                endcase
            end
        endcase
        e.wrEn   = wr && (dst != 5'd0);     // r0 never written
        e.wrAddr = dst;
        e.wrData = res;
        if (e.wrEn)
            shadow[dst] = res;
        return e;
    endfunction

    task automatic issue(input logic valid, input word_t inst, input word_t pc);
        @(posedge clk);
        instValid_i <= valid;
        inst_i      <= inst;
        pc_i        <= pc;
        expQ.push_back(predict(valid, inst, pc));
    endtask

    task automatic holdReset();
        expect_t z;
        z      = '0;
        z.full = 1'b1;
        repeat (4)
        begin
            @(posedge clk);
            expQ.push_back(z);
        end
        @(posedge clk);
        rst_i <= 1'b0;                      // 5th cycle ends reset
        expQ.push_back(expect_t'(0));
    endtask

    task automatic reportMismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    ////////////////////
    // output checks
    ////////////////////

    always @(negedge clk)
    begin
        if (expQ.size() > 1)
        begin
            cur   = expQ.pop_front();
            chkWr = cur.full || cur.wrEn;
            chkJ  = cur.full || cur.jCe;
            checks++;
            assert (wrEn_o === cur.wrEn)
            else reportMismatch("wrEn_o", 32'(wrEn_o), 32'(cur.wrEn));
            assert (jCe_o === cur.jCe)
            else reportMismatch("jCe_o", 32'(jCe_o), 32'(cur.jCe));
            if (chkWr)
            begin
                assert (wrAddr_o === cur.wrAddr)
                else reportMismatch("wrAddr_o", 32'(wrAddr_o), 32'(cur.wrAddr));
                assert (wrData_o === cur.wrData)
                else reportMismatch("wrData_o", wrData_o, cur.wrData);
            end
            if (chkJ)
            begin
                assert (jAddr_o === cur.jAddr)
                else reportMismatch("jAddr_o", jAddr_o, cur.jAddr);
            end
        end
    end

    initial
    begin
        #(MaxCycles * ClkPeriod);
        $display("timeout after %0d cycles, stimulus did not finish", MaxCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        logic [4:0] rs;
        logic [4:0] sel;
        rst_i       = 1'b1;
        instValid_i = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        for (int r = 0; r < `MIPS_NUM_REGS; r++)
            shadow[r] = '0;
        holdReset();

        // lui then dependent ori on the same register
        for (int r = 1; r < `MIPS_NUM_REGS; r++)
        begin
            issue(1'b1, iType(OpLui, 5'd0, 5'(r), 16'(randBits(16))), randPc());
            issue(1'b1, iType(OpOri, 5'(r), 5'(r), 16'(randBits(16))), randPc());
        end

        for (int k = 0; k < NumAlu; k++)
        begin
            if (randBits(3) == 0)
                issue(1'b0, jType(OpJal, 26'(randBits(26))), randPc());  // bubble, no write or jump
            issue(1'b1, rType(randReg(), randReg(), randReg(), randReg(), randAluFunct()),
                  randPc());
        end

        for (int k = 0; k < NumImm; k++)
            issue(1'b1, iType(randImmOp(), randReg(), randReg(), 16'(randBits(16))), randPc());

        // r0 writes dropped, r0 reads back zero
        issue(1'b1, iType(OpAddi, 5'd5, 5'd0, 16'h8123), randPc());
        issue(1'b1, rType(5'd0, 5'd0, 5'd7, 5'd0, FnOr), randPc());
        issue(1'b1, rType(5'd0, 5'd3, 5'd8, 5'd0, FnAdd), randPc());
        repeat (4)
            issue(1'b1, iType(OpAddi, 5'd9, 5'd9, 16'hffff), randPc());

        issue(1'b1, iType(OpBgtz, 5'd0, 5'd0, 16'h0010), randPc());
        issue(1'b1, iType(OpBltz, 5'd0, 5'd0, 16'h0010), randPc());
        issue(1'b1, iType(OpBeq, 5'd4, 5'd4, 16'hfff0), randPc());
        for (int k = 0; k < NumBr; k++)
        begin
            rs  = randReg();
            sel = 5'(randBits(2));
            case (sel)
                0:  issue(1'b1, iType(OpBeq, rs, randBits(1) ? rs : randReg(),
                                      16'(randBits(16))), randPc());
                1:  issue(1'b1, iType(OpBne, rs, randBits(1) ? rs : randReg(),
                                      16'(randBits(16))), randPc());
                2:  issue(1'b1, iType(OpBgtz, rs, 5'd0, 16'(randBits(16))), randPc());
                default: issue(1'b1, iType(OpBltz, rs, 5'd0, 16'(randBits(16))), randPc());
            endcase
        end

        for (int k = 0; k < NumJmp; k++)
        begin
            sel = 5'(randBits(2));
            case (sel)
                0:  issue(1'b1, jType(OpJ, 26'(randBits(26))), randPc());
                1:  issue(1'b1, jType(OpJal, 26'(randBits(26))), randPc());
                2:  issue(1'b1, rType(randReg(), 5'd0, 5'd0, 5'd0, FnJr), randPc());
                default: issue(1'b1, rType(randReg(), 5'd0, randReg(), 5'd0, FnJalr), randPc());
            endcase
            issue(1'b1, rType(5'd31, 5'd0, 5'd10, 5'd0, FnOr), randPc());  // reads link
        end

        issue(1'b0, '0, '0);
        issue(1'b0, '0, '0);
        @(posedge clk);
        $display("checked cycles %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
